// ==== src.f ====
hw/sm83_pkg.sv
hw/ctrl_if.sv
hw/mcycle_sequencer.sv
hw/reg_file.sv
hw/alu.sv
hw/bus_unit.sv
hw/sm83_core.sv
tb/sm83_asserts.sv
tb/sm83_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sm83_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/sm83_tb.sv ====
`timescale 1ns/10ps

module sm83_tb;
  import sm83_pkg::*;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] bus_addr;
  logic              bus_rd;
  logic              bus_wr;
  logic [DATA_W-1:0] bus_wdata;
  logic [DATA_W-1:0] bus_rdata;

  logic [7:0]  mem [65536];
  logic [7:0]  prog [$];
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];

  // Reference model state
  logic [7:0]  mr [8];
  logic        mc;
  logic [7:0]  mwr [logic [15:0]];

  logic [31:0] lcg_state = 32'h5b2b;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          cycle_count = 0;
  int          budget = 100000;

  sm83_core DUT (
    .clk       (clk),
    .rst       (rst),
    .bus_addr  (bus_addr),
    .bus_rd    (bus_rd),
    .bus_wr    (bus_wr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata)
  );

  // Asynchronous read memory
  assign bus_rdata = mem[bus_addr];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Every write must match the head of the expected queue
  always @(negedge clk) begin
    if (bus_wr) begin
      if (exp_addr.size() == 0) begin
        $display("Unexpected write of %h to address %h at %0t", bus_wdata, bus_addr, $time);
        errors++;
      end else begin
        checks++;
        assert (bus_addr == exp_addr[0] && bus_wdata == exp_data[0])
          else begin
            $display("Mismatch at %0t: expected %h to %h, got %h to %h", $time,
                     exp_data[0], exp_addr[0], bus_wdata, bus_addr);
            errors++;
          end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
      mem[bus_addr] = bus_wdata;
    end
  end

  // Watchdog with a per-test budget from the program length
  initial begin
    while (cycle_count <= budget) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: test %0d did not reach the end of its program in %0d cycles",
             tests_run + 1, budget);
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [7:0] rand8();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
  endfunction

  function automatic logic [15:0] model_hl();
    return {mr[4], mr[5]};
  endfunction

  function automatic logic [7:0] model_mem(input logic [15:0] a);
    return mwr.exists(a) ? mwr[a] : fill_byte(a);
  endfunction

  // Returns the carry and the result with the borrow in bit 8 for subtraction
  function automatic logic [8:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                           input logic [7:0] b, input logic cin);
    logic [8:0] r;
    case (op)
      3'd0: r = {1'b0, a} + {1'b0, b};
      3'd1: r = {1'b0, a} + {1'b0, b} + {8'd0, cin};
      3'd2, 3'd7: r = {1'b0, a} - {1'b0, b};
      3'd3: r = {1'b0, a} - {1'b0, b} - {8'd0, cin};
      3'd4: r = {1'b0, a & b};
      3'd5: r = {1'b0, a ^ b};
      default: r = {1'b0, a | b};
    endcase
    return r;
  endfunction

  task automatic emit(input logic [7:0] b);
    prog.push_back(b);
  endtask

  task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    mwr[a] = d;
  endtask

  task automatic begin_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    mwr.delete();
    for (int i = 0; i < 8; i++) begin
      mr[i] = 8'h00;
    end
    mc = 1'b0;
  endtask

  task automatic ld_r_n(input reg_sel_t r, input logic [7:0] n);
    emit({2'b00, r[2:0], 3'b110});
    emit(n);
    mr[r[2:0]] = n;
  endtask

  task automatic ld_r_r(input reg_sel_t d, input reg_sel_t s);
    emit({2'b01, d[2:0], s[2:0]});
    mr[d[2:0]] = mr[s[2:0]];
  endtask

  task automatic store(input reg_sel_t s);
    emit({5'b01110, s[2:0]});
    expect_write(model_hl(), mr[s[2:0]]);
  endtask

  task automatic ld_hl_n(input logic [7:0] n);
    emit(8'h36);
    emit(n);
    expect_write(model_hl(), n);
  endtask

  task automatic ld_r_hl(input reg_sel_t d);
    emit({2'b01, d[2:0], 3'b110});
    mr[d[2:0]] = model_mem(model_hl());
  endtask

  task automatic apply_alu(input alu_op_t op, input logic [7:0] b);
    logic [8:0] r;
    r = alu_model(op, mr[7], b, mc);
    mc = r[8];
    if (op != ALU_CP) begin
      mr[7] = r[7:0];
    end
  endtask

  task automatic alu_r(input alu_op_t op, input reg_sel_t s);
    emit({2'b10, op, s[2:0]});
    apply_alu(op, mr[s[2:0]]);
  endtask

  task automatic alu_n(input alu_op_t op, input logic [7:0] n);
    emit({2'b11, op, 3'b110});
    emit(n);
    apply_alu(op, n);
  endtask

  task automatic alu_hl(input alu_op_t op);
    emit({2'b10, op, 3'b110});
    apply_alu(op, model_mem(model_hl()));
  endtask

  // INC/DEC leave the carry alone
  task automatic inc_dec_r(input reg_sel_t r, input logic dec);
    emit({2'b00, r[2:0], 2'b10, dec});
    mr[r[2:0]] = dec ? mr[r[2:0]] - 8'd1 : mr[r[2:0]] + 8'd1;
  endtask

  task automatic inc_dec_hl(input logic dec);
    logic [7:0] v;
    emit({7'b0011010, dec});
    v = model_mem(model_hl());
    expect_write(model_hl(), dec ? v - 8'd1 : v + 8'd1);
  endtask

  task automatic set_carry(input logic c);
    ld_r_n(REG_A, 8'hFF);
    alu_n(ALU_ADD, {7'd0, c});
  endtask

  task automatic point_hl();
    ld_r_n(REG_H, 8'h40 | (rand8() & 8'h3F));
    ld_r_n(REG_L, rand8());
  endtask

  task automatic run_program(input string name);
    int end_addr;
    int errs_before;
    bit done;
    errs_before = errors;
    end_addr = prog.size();
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = fill_byte(16'(i));
    end
    for (int i = 0; i < end_addr; i++) begin
      mem[i] = prog[i];
    end
    // NOP padding after the program
    for (int i = 0; i < 4; i++) begin
      mem[end_addr + i] = OPC_NOP;
    end
    cycle_count = 0;
    budget = 40 * end_addr + 8;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (bus_rd && bus_addr == 16'(end_addr)) begin
        done = 1'b1;
      end
    end
    if (exp_addr.size() != 0) begin
      $display("Test %s: %0d expected writes never happened", name, exp_addr.size());
      errors++;
    end
    tests_run++;
    $display("Test %0d %s finished with %0d errors", tests_run, name, errors - errs_before);
  endtask

  initial begin
    int total;
    alu_op_t op;
    reg_sel_t dst [5];
    rst = 1'b1;
    dst = '{REG_B, REG_C, REG_D, REG_E, REG_A};

    begin_program();
    for (int i = 0; i < 5; i++) begin
      ld_r_n(dst[i], rand8());
    end
    point_hl();
    for (int i = 0; i < 5; i++) begin
      store(dst[i]);
    end
    store(REG_H);
    store(REG_L);
    ld_r_r(REG_C, REG_B);
    ld_r_r(REG_D, REG_C);
    ld_r_r(REG_E, REG_D);
    ld_r_r(REG_A, REG_E);
    store(REG_A);
    ld_r_r(REG_L, REG_A);
    store(REG_L);
    run_program("load chains");

    begin_program();
    for (int o = 0; o < 8; o++) begin
      op = alu_op_t'(o);
      for (int form = 0; form < 3; form++) begin
        if (op == ALU_ADC || op == ALU_SBC) begin
          set_carry(rand8() > 8'h60);
        end
        point_hl();
        ld_r_n(REG_A, rand8());
        ld_r_n(REG_B, rand8());
        case (form)
          0: alu_r(op, REG_B);
          1: alu_n(op, rand8());
          default: alu_hl(op);
        endcase
        store(REG_A);
      end
    end
    run_program("alu operations");

    begin_program();
    point_hl();
    ld_r_n(REG_B, 8'hFF);
    inc_dec_r(REG_B, 1'b0);
    store(REG_B);
    ld_r_n(REG_C, 8'h00);
    inc_dec_r(REG_C, 1'b1);
    store(REG_C);
    ld_hl_n(8'hFF);
    inc_dec_hl(1'b0);
    inc_dec_hl(1'b1);
    inc_dec_hl(1'b0);
    for (int c = 0; c < 2; c++) begin
      set_carry(c[0]);
      ld_r_n(REG_D, 8'hFF);
      inc_dec_r(REG_D, 1'b0);
      ld_r_n(REG_A, rand8());
      alu_r(ALU_ADC, REG_D);
      store(REG_A);
    end
    run_program("inc and dec");

    begin_program();
    for (int k = 0; k < 5; k++) begin
      point_hl();
      ld_hl_n(rand8());
      ld_r_hl(dst[k]);
      ld_r_n(REG_L, rand8());
      store(dst[k]);
    end
    run_program("memory round trip");

    total = errors + DUT.u_asserts.fail_count;
    $display("Tests: %0d, write checks: %0d, errors: %0d, assertion failures: %0d",
             tests_run, checks, errors, DUT.u_asserts.fail_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/sm83_asserts.sv ====
`timescale 1ns/10ps

module sm83_asserts (
  input logic                         clk,
  input logic                         rst,
  input logic [sm83_pkg::ADDR_W-1:0]  bus_addr,
  input logic                         bus_rd,
  input logic                         bus_wr,
  input sm83_pkg::bus_op_t            bus_op,
  input logic                         pc_inc
);
  import sm83_pkg::*;

  int                fail_count = 0;
  logic [ADDR_W-1:0] next_pc;

  // Fetches and immediate reads both walk the PC forward
  always_ff @(posedge clk) begin
    if (rst) begin
      next_pc <= RESET_PC;
    end else if (bus_rd && pc_inc) begin
      next_pc <= bus_addr + ADDR_W'(1);
    end
  end

  strobes_exclusive: assert property (@(posedge clk) !(bus_rd && bus_wr))
    else begin
      $error("bus_rd and bus_wr high together");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk) rst |-> (!bus_rd && !bus_wr))
    else begin
      $error("bus strobe active during reset");
      fail_count++;
    end

  first_fetch: assert property (@(posedge clk) $fell(rst) |-> (bus_rd && bus_addr == RESET_PC))
    else begin
      $error("first access after reset is not a fetch of the reset address");
      fail_count++;
    end

  fetch_sequence: assert property (@(posedge clk) disable iff (rst)
      (bus_op == BUS_FETCH) |-> (bus_addr == next_pc))
    else begin
      $error("fetch address does not follow the previous PC access");
      fail_count++;
    end

endmodule

bind sm83_core sm83_asserts u_asserts (
  .clk      (clk),
  .rst      (rst),
  .bus_addr (bus_addr),
  .bus_rd   (bus_rd),
  .bus_wr   (bus_wr),
  .bus_op   (ctl.bus_op),
  .pc_inc   (ctl.pc_inc)
);

// ==== hw/sm83_core.sv ====
`timescale 1ns/10ps

module sm83_core (
  input  logic                         clk,
  input  logic                         rst,
  output logic [sm83_pkg::ADDR_W-1:0]  bus_addr,
  output logic                         bus_rd,
  output logic                         bus_wr,
  output logic [sm83_pkg::DATA_W-1:0]  bus_wdata,
  input  logic [sm83_pkg::DATA_W-1:0]  bus_rdata
);
  import sm83_pkg::*;

  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] alu_result;
  logic [ADDR_W-1:0] hl;

  // Control word for the current M-cycle
  ctrl_if ctl ();

  mcycle_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .bus_rdata (bus_rdata),
    .ctl       (ctl.seq)
  );

  reg_file u_rf (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl.exec),
    .bus_rdata  (bus_rdata),
    .alu_result (alu_result),
    .rd_data    (rd_data),
    .acc        (acc),
    .hl         (hl)
  );

  alu u_alu (
    .clk     (clk),
    .rst     (rst),
    .ctl     (ctl.exec),
    .acc     (acc),
    .rd_data (rd_data),
    .result  (alu_result)
  );

  bus_unit u_bus (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl.exec),
    .hl         (hl),
    .rd_data    (rd_data),
    .alu_result (alu_result),
    .bus_addr   (bus_addr),
    .bus_rd     (bus_rd),
    .bus_wr     (bus_wr),
    .bus_wdata  (bus_wdata)
  );

endmodule

// ==== hw/bus_unit.sv ====
`timescale 1ns/10ps

module bus_unit (
  input  logic                         clk,
  input  logic                         rst,
  ctrl_if.exec                         ctl,
  input  logic [sm83_pkg::ADDR_W-1:0]  hl,
  input  logic [sm83_pkg::DATA_W-1:0]  rd_data,
  input  logic [sm83_pkg::DATA_W-1:0]  alu_result,
  output logic [sm83_pkg::ADDR_W-1:0]  bus_addr,
  output logic                         bus_rd,
  output logic                         bus_wr,
  output logic [sm83_pkg::DATA_W-1:0]  bus_wdata
);
  import sm83_pkg::*;

  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;

  // PC increment unit
  assign pc_next = pc + ADDR_W'(1);

  // Advances on opcode fetches and immediate reads
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (ctl.pc_inc) begin
      pc <= pc_next;
    end
  end

  assign bus_addr = (ctl.addr_sel == ADDR_HL) ? hl : pc;

  // Stores take a register, INC/DEC [HL] writes back the ALU result
  assign bus_wdata = (ctl.dout_sel == DOUT_ALU) ? alu_result : rd_data;

  assign bus_rd = (ctl.bus_op == BUS_FETCH) || (ctl.bus_op == BUS_READ);
  assign bus_wr = (ctl.bus_op == BUS_WRITE);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
  input  logic                         clk,
  input  logic                         rst,
  ctrl_if.exec                         ctl,
  input  logic [sm83_pkg::DATA_W-1:0]  acc,
  input  logic [sm83_pkg::DATA_W-1:0]  rd_data,
  output logic [sm83_pkg::DATA_W-1:0]  result
);
  import sm83_pkg::*;

  flags_t            flags;
  flags_t            flags_new;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic              carry_in;
  logic [DATA_W:0]   add_full;
  logic [DATA_W:0]   sub_full;
  logic [4:0]        add_half;
  logic [4:0]        sub_half;

  assign op_a = (ctl.alu_a_sel == ALU_A_ACC) ? acc : rd_data;

  always_comb begin
    case (ctl.alu_b_sel)
      ALU_B_REG: op_b = rd_data;
      ALU_B_ONE: op_b = DATA_W'(1);
      default:   op_b = '0;
    endcase
  end

  // Stored carry only enters ADC and SBC
  assign carry_in = (ctl.alu_op == ALU_ADC || ctl.alu_op == ALU_SBC) && flags.c;

  assign add_full = {1'b0, op_a} + {1'b0, op_b} + {{DATA_W{1'b0}}, carry_in};
  assign sub_full = {1'b0, op_a} - {1'b0, op_b} - {{DATA_W{1'b0}}, carry_in};
  assign add_half = {1'b0, op_a[3:0]} + {1'b0, op_b[3:0]} + {4'b0, carry_in};
  assign sub_half = {1'b0, op_a[3:0]} - {1'b0, op_b[3:0]} - {4'b0, carry_in};

  always_comb begin
    case (ctl.alu_op)
      ALU_ADD, ALU_ADC: begin
        result      = add_full[DATA_W-1:0];
        flags_new.n = 1'b0;
        flags_new.h = add_half[4];
        flags_new.c = add_full[DATA_W];
      end
      ALU_AND: begin
        result      = op_a & op_b;
        flags_new.n = 1'b0;
        flags_new.h = 1'b1;
        flags_new.c = 1'b0;
      end
      ALU_XOR, ALU_OR: begin
        result      = (ctl.alu_op == ALU_XOR) ? (op_a ^ op_b) : (op_a | op_b);
        flags_new.n = 1'b0;
        flags_new.h = 1'b0;
        flags_new.c = 1'b0;
      end
      // SUB, SBC and CP, borrow shows up as the top bit
      default: begin
        result      = sub_full[DATA_W-1:0];
        flags_new.n = 1'b1;
        flags_new.h = sub_half[4];
        flags_new.c = sub_full[DATA_W];
      end
    endcase
    flags_new.z = (result == '0);
  end

  // Masked update, kept bits hold their old value
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (ctl.flags_we) begin
      flags <= flags_t'((flags & ctl.flag_keep) | (flags_new & ~ctl.flag_keep));
    end
  end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                         clk,
  input  logic                         rst,
  ctrl_if.exec                         ctl,
  input  logic [sm83_pkg::DATA_W-1:0]  bus_rdata,
  input  logic [sm83_pkg::DATA_W-1:0]  alu_result,
  output logic [sm83_pkg::DATA_W-1:0]  rd_data,
  output logic [sm83_pkg::DATA_W-1:0]  acc,
  output logic [sm83_pkg::ADDR_W-1:0]  hl
);
  import sm83_pkg::*;

  // Indexed by reg_sel_t with slot 6 left empty
  logic [DATA_W-1:0] regs [int'(REG_Z) + 1];
  logic [DATA_W-1:0] wr_data;

  // Loads take the bus byte and all other writes the ALU result
  assign wr_data = ctl.rf_wr_from_bus ? bus_rdata : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= int'(REG_Z); i++) begin
        regs[i] <= '0;
      end
    end else if (ctl.rf_we) begin
      regs[ctl.rf_wr_reg] <= wr_data;
    end
  end

  // Single read port feeding the ALU and the write data mux
  assign rd_data = regs[ctl.rf_rd_reg];

  // Accumulator always visible to the ALU A operand
  assign acc = regs[REG_A];

  // Pointer for the [HL] forms
  assign hl = {regs[REG_H], regs[REG_L]};

endmodule

// ==== hw/mcycle_sequencer.sv ====
`timescale 1ns/10ps

module mcycle_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [sm83_pkg::DATA_W-1:0]  bus_rdata,
  ctrl_if.seq                          ctl
);
  import sm83_pkg::*;

  logic [DATA_W-1:0] opcode;
  logic [1:0]        mcyc;
  logic [1:0]        grp;
  logic [2:0]        dst;
  logic [2:0]        src;
  bus_op_t           bus_op_dec;

  assign grp = opcode[7:6];
  assign dst = opcode[5:3];
  assign src = opcode[2:0];

  // No bus cycles while held in reset
  assign ctl.bus_op = rst ? BUS_IDLE : bus_op_dec;

  // Last cycle of every instruction is the fetch of the next opcode
  always_ff @(posedge clk) begin
    if (rst) begin
      opcode <= OPC_NOP;
      mcyc   <= 2'd0;
    end else if (bus_op_dec == BUS_FETCH) begin
      opcode <= bus_rdata;
      mcyc   <= 2'd0;
    end else begin
      mcyc <= mcyc + 2'd1;
    end
  end

  always_comb begin
    // Default cycle: fetch at PC, nothing written
    bus_op_dec         = BUS_FETCH;
    ctl.addr_sel       = ADDR_PC;
    ctl.pc_inc         = 1'b1;
    ctl.rf_rd_reg      = REG_A;
    ctl.rf_we          = 1'b0;
    ctl.rf_wr_reg      = REG_A;
    ctl.rf_wr_from_bus = 1'b0;
    ctl.alu_op         = ALU_ADD;
    ctl.alu_a_sel      = ALU_A_REG;
    ctl.alu_b_sel      = ALU_B_ZERO;
    ctl.flags_we       = 1'b0;
    ctl.flag_keep      = '0;
    ctl.dout_sel       = DOUT_REG;

    case (grp)
      2'b00: begin
        if (src == 3'b110) begin
          // LD r,n and LD [HL],n
          if (mcyc == 2'd0) begin
            bus_op_dec         = BUS_READ;
            ctl.rf_we          = 1'b1;
            ctl.rf_wr_reg      = REG_Z;
            ctl.rf_wr_from_bus = 1'b1;
          end else if (dst == 3'b110 && mcyc == 2'd1) begin
            bus_op_dec    = BUS_WRITE;
            ctl.addr_sel  = ADDR_HL;
            ctl.pc_inc    = 1'b0;
            ctl.rf_rd_reg = REG_Z;
          end else if (dst != 3'b110) begin
            // Z copied into r through the ALU, flags untouched
            ctl.rf_rd_reg = REG_Z;
            ctl.rf_we     = 1'b1;
            ctl.rf_wr_reg = reg_sel_t'({1'b0, dst});
          end
        end else if (src[2:1] == 2'b10) begin
          // INC/DEC, carry flag preserved
          ctl.alu_op      = src[0] ? ALU_SUB : ALU_ADD;
          ctl.alu_b_sel   = ALU_B_ONE;
          ctl.flag_keep.c = 1'b1;
          if (dst == 3'b110) begin
            if (mcyc == 2'd0) begin
              bus_op_dec         = BUS_READ;
              ctl.addr_sel       = ADDR_HL;
              ctl.pc_inc         = 1'b0;
              ctl.rf_we          = 1'b1;
              ctl.rf_wr_reg      = REG_Z;
              ctl.rf_wr_from_bus = 1'b1;
            end else if (mcyc == 2'd1) begin
              bus_op_dec    = BUS_WRITE;
              ctl.addr_sel  = ADDR_HL;
              ctl.pc_inc    = 1'b0;
              ctl.rf_rd_reg = REG_Z;
              ctl.dout_sel  = DOUT_ALU;
              ctl.flags_we  = 1'b1;
            end
          end else begin
            ctl.rf_rd_reg = reg_sel_t'({1'b0, dst});
            ctl.rf_we     = 1'b1;
            ctl.rf_wr_reg = reg_sel_t'({1'b0, dst});
            ctl.flags_we  = 1'b1;
          end
        end
      end

      2'b01: begin
        if (src == 3'b110 && dst != 3'b110) begin
          // LD r,[HL] via Z
          if (mcyc == 2'd0) begin
            bus_op_dec         = BUS_READ;
            ctl.addr_sel       = ADDR_HL;
            ctl.pc_inc         = 1'b0;
            ctl.rf_we          = 1'b1;
            ctl.rf_wr_reg      = REG_Z;
            ctl.rf_wr_from_bus = 1'b1;
          end else begin
            ctl.rf_rd_reg = REG_Z;
            ctl.rf_we     = 1'b1;
            ctl.rf_wr_reg = reg_sel_t'({1'b0, dst});
          end
        end else if (dst == 3'b110 && src != 3'b110) begin
          // LD [HL],r
          if (mcyc == 2'd0) begin
            bus_op_dec    = BUS_WRITE;
            ctl.addr_sel  = ADDR_HL;
            ctl.pc_inc    = 1'b0;
            ctl.rf_rd_reg = reg_sel_t'({1'b0, src});
          end
        end else if (dst != 3'b110) begin
          // LD r,r'
          ctl.rf_rd_reg = reg_sel_t'({1'b0, src});
          ctl.rf_we     = 1'b1;
          ctl.rf_wr_reg = reg_sel_t'({1'b0, dst});
        end
      end

      default: begin
        // ALU r / ALU [HL] in group 10, ALU n in group 11
        if (grp == 2'b10 || src == 3'b110) begin
          if (src == 3'b110 && mcyc == 2'd0) begin
            bus_op_dec         = BUS_READ;
            ctl.addr_sel       = (grp == 2'b10) ? ADDR_HL : ADDR_PC;
            ctl.pc_inc         = (grp == 2'b11);
            ctl.rf_we          = 1'b1;
            ctl.rf_wr_reg      = REG_Z;
            ctl.rf_wr_from_bus = 1'b1;
          end else begin
            ctl.rf_rd_reg = (src == 3'b110) ? REG_Z : reg_sel_t'({1'b0, src});
            ctl.alu_op    = alu_op_t'(dst);
            ctl.alu_a_sel = ALU_A_ACC;
            ctl.alu_b_sel = ALU_B_REG;
            // CP only sets flags
            ctl.rf_we     = (alu_op_t'(dst) != ALU_CP);
            ctl.rf_wr_reg = REG_A;
            ctl.flags_we  = 1'b1;
          end
        end
      end
    endcase
  end

endmodule

// ==== hw/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if;
  import sm83_pkg::*;

  bus_op_t    bus_op;
  addr_sel_t  addr_sel;
  logic       pc_inc;
  reg_sel_t   rf_rd_reg;
  logic       rf_we;
  reg_sel_t   rf_wr_reg;
  logic       rf_wr_from_bus;
  alu_op_t    alu_op;
  alu_a_sel_t alu_a_sel;
  alu_b_sel_t alu_b_sel;
  logic       flags_we;
  // Set bits hold the old flag value
  flags_t     flag_keep;
  dout_sel_t  dout_sel;

  modport seq (
    output bus_op, addr_sel, pc_inc, rf_rd_reg, rf_we, rf_wr_reg, rf_wr_from_bus,
    output alu_op, alu_a_sel, alu_b_sel, flags_we, flag_keep, dout_sel
  );

  modport exec (
    input bus_op, addr_sel, pc_inc, rf_rd_reg, rf_we, rf_wr_reg, rf_wr_from_bus,
    input alu_op, alu_a_sel, alu_b_sel, flags_we, flag_keep, dout_sel
  );

endinterface

// ==== hw/sm83_pkg.sv ====
package sm83_pkg;

  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  localparam logic [ADDR_W-1:0] RESET_PC = 16'h0000;
  localparam logic [DATA_W-1:0] OPC_NOP  = 8'h00;

  // Codes 0..7 match the r field of the opcode, code 6 is [HL] there
  typedef enum logic [3:0] {
    REG_B = 4'd0,
    REG_C = 4'd1,
    REG_D = 4'd2,
    REG_E = 4'd3,
    REG_H = 4'd4,
    REG_L = 4'd5,
    REG_A = 4'd7,
    REG_Z = 4'd8
  } reg_sel_t;

  // Same order as opcode bits 5:3
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_SBC,
    ALU_AND,
    ALU_XOR,
    ALU_OR,
    ALU_CP
  } alu_op_t;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_FETCH,
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  typedef enum logic {ADDR_PC, ADDR_HL} addr_sel_t;
  typedef enum logic {ALU_A_ACC, ALU_A_REG} alu_a_sel_t;
  typedef enum logic [1:0] {ALU_B_REG, ALU_B_ONE, ALU_B_ZERO} alu_b_sel_t;
  typedef enum logic {DOUT_REG, DOUT_ALU} dout_sel_t;

  // Upper nibble of F
  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flags_t;

endpackage
